// ==== Makefile ====
# Sprite line renderer, Verilator lint and simulation
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module obj_tb

sim:
	verilator --binary --timing --assert -f vlog.f --top-module obj_tb -Mdir obj_dir
	./obj_dir/Vobj_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TESTBENCH FAILED" $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== src/obj_config.svh ====
/*
 * Sprite renderer configuration
 * Table size, line buffer width and graphics ROM address width
 */
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// Sprite attribute table
`define OBJ_COUNT  16
`define OBJ_IDX_W  4

// Graphics ROM word address, bank plus offset
`define OBJ_ROM_AW 20

// Line buffer address, 512 pixels per half
`define OBJ_BUF_AW 9

`endif

// ==== src/obj_draw.sv ====
/*
 * Sprite row drawer
 * Fetches ROM words and writes opaque pixels into the line buffer
 */
`timescale 1ns/1ns

module obj_draw (
    input  logic                clk,
    input  logic                rst,
    input  logic                hstart,
    input  logic                start,
    output logic                busy,
    input  obj_pkg::obj_job_t   job,
    input  logic                obj_ok,
    output logic                obj_cs,
    output obj_pkg::rom_addr_t  obj_addr,
    input  obj_pkg::rom_word_t  obj_data,
    output logic                bf_we,
    output obj_pkg::xpos_t      bf_addr,
    output obj_pkg::bf_pxl_t    bf_data
);

    obj_pkg::obj_job_t  job_q;     // Latched request
    obj_pkg::rom_word_t pxl_data;  // Pixel shifter
    logic [15:0]        cur;       // Current word offset
    logic [1:0]         cnt;       // Pixel within word
    logic               draw;
    logic               skip;      // Ignore obj_ok after address change
    logic [3:0]         cur_pxl;
    logic [3:0]         nxt_pxl;
    logic [3:0]         first_pxl;
    logic               fetch_ack;
    logic               step;

    // Pixel order follows hflip
    assign cur_pxl   = job_q.hflip ? pxl_data[3:0] : pxl_data[15:12];
    assign nxt_pxl   = job_q.hflip ? pxl_data[7:4] : pxl_data[11:8];
    assign first_pxl = job_q.hflip ? obj_data[3:0] : obj_data[15:12];

    assign obj_addr  = {job_q.bank, cur};          // Bank then offset
    assign bf_data   = {job_q.prio, job_q.pal, cur_pxl};

    assign fetch_ack = busy && !draw && obj_cs && !skip && obj_ok;
    assign step      = busy && !draw && !obj_cs;   // Move to next word

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            draw   <= 1'b0;
            obj_cs <= 1'b0;
            bf_we  <= 1'b0;
            skip   <= 1'b0;
        end else if (hstart) begin
            busy   <= 1'b0;   // Abort at line start
            draw   <= 1'b0;
            obj_cs <= 1'b0;
            bf_we  <= 1'b0;
            skip   <= 1'b0;
        end else if (start) begin
            busy   <= 1'b1;
            draw   <= 1'b0;
            obj_cs <= 1'b1;
            bf_we  <= 1'b0;
            skip   <= 1'b1;
        end else begin
            bf_we <= 1'b0;
            if (draw) begin
                if (cnt == 2'd3) begin
                    draw <= 1'b0;
                    if (&cur_pxl)
                        busy <= 1'b0;      // End marker in last pixel
                end else begin
                    bf_we <= ~&nxt_pxl;    // $F stays transparent
                end
            end else if (busy) begin
                if (!obj_cs) begin
                    obj_cs <= 1'b1;
                    skip   <= 1'b1;
                end else if (skip) begin
                    skip <= 1'b0;          // Stale acknowledge window
                end else if (obj_ok) begin
                    obj_cs <= 1'b0;
                    draw   <= 1'b1;
                    bf_we  <= ~&first_pxl;
                end
            end
        end
    end

    // Address and pixel datapath
    always_ff @(posedge clk) begin
        if (start) begin
            job_q   <= job;
            cur     <= job.addr;
            bf_addr <= job.xpos;
        end else if (fetch_ack) begin
            pxl_data <= obj_data;
            cnt      <= 2'd0;
        end else if (step) begin
            cur <= job_q.hflip ? cur - 16'd1 : cur + 16'd1;
        end else if (draw) begin
            pxl_data <= job_q.hflip ? pxl_data >> 4 : pxl_data << 4;
            cnt      <= cnt + 2'd1;
            bf_addr  <= bf_addr + 9'd1;    // Every pixel, drawn or not
        end
    end

    // ROM address held until a counted acknowledge
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (obj_cs && !(obj_ok && !skip)) |=> $stable(obj_addr));

endmodule

// ==== src/obj_linebuf.sv ====
/*
 * Double line buffer
 * Draw side writes one half, video reads and clears the other
 */
`timescale 1ns/1ns
`include "obj_config.svh"

module obj_linebuf (
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,
    input  logic              bf_we,
    input  obj_pkg::xpos_t    bf_addr,
    input  obj_pkg::bf_pxl_t  bf_data,
    input  logic              rd_en,
    input  obj_pkg::xpos_t    rd_addr,
    output obj_pkg::bf_pxl_t  rd_pxl
);

    logic           bank;       // Current draw half
    logic           rd_half_q;  // Half of last read
    logic           clr_busy;
    obj_pkg::xpos_t clr_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank      <= 1'b0;
            rd_half_q <= 1'b0;
            clr_busy  <= 1'b1;     // Start the fill
            clr_addr  <= '0;
        end else begin
            if (hstart)
                bank <= ~bank;     // Swap halves
            if (rd_en)
                rd_half_q <= ~bank;
            if (clr_busy) begin
                clr_addr <= clr_addr + 9'd1;
                if (&clr_addr)
                    clr_busy <= 1'b0;
            end
        end
    end

    for (genvar h = 0; h < 2; h++) begin : g_half
        obj_pkg::bf_pxl_t mem [0:(1 << `OBJ_BUF_AW) - 1];
        obj_pkg::bf_pxl_t q;
        obj_pkg::bf_pxl_t wdata;
        obj_pkg::xpos_t   waddr;
        logic             draw_side;
        logic             we;

        assign draw_side = bank == 1'(h);
        assign we        = clr_busy || (draw_side ? bf_we : rd_en);
        assign waddr     = clr_busy ? clr_addr : (draw_side ? bf_addr : rd_addr);
        assign wdata     = (clr_busy || !draw_side) ? '1 : bf_data; // Clear to transparent

        always_ff @(posedge clk) begin
            if (we)
                mem[waddr] <= wdata;
            if (rd_en && !draw_side)
                q <= mem[rd_addr]; // Old value before clear
        end
    end

    assign rd_pxl = rd_half_q ? g_half[1].q : g_half[0].q;

    // Fill owns both halves, no draw write or video read until it ends
    a_fill_quiet: assert property (@(posedge clk) disable iff (rst)
        clr_busy |-> !(bf_we || rd_en));

endmodule

// ==== src/obj_pkg.sv ====
/*
 * Sprite renderer types
 * Widths, sprite table entry, draw job and scanner states
 */
`include "obj_config.svh"

package obj_pkg;

    typedef logic [`OBJ_BUF_AW-1:0] xpos_t;     // Horizontal pixel position
    typedef logic [7:0]             line_t;     // Video line number
    typedef logic [`OBJ_ROM_AW-1:0] rom_addr_t; // ROM word address
    typedef logic [15:0]            rom_word_t; // Four pixels, first in top nibble
    typedef logic [11:0]            bf_pxl_t;   // prio, pal, colour ($F transparent)

    typedef struct packed {
        line_t       top;
        logic [7:0]  height;  // Zero disables the entry
        xpos_t       xpos;
        logic [15:0] offset;
        logic [7:0]  pitch;   // Words per row
        logic [3:0]  bank;
        logic [1:0]  prio;
        logic [5:0]  pal;
        logic        hflip;
    } obj_entry_t;

    typedef struct packed {
        xpos_t       xpos;
        logic [15:0] addr;    // Row start, offset + row * pitch
        logic [3:0]  bank;
        logic [1:0]  prio;
        logic [5:0]  pal;
        logic        hflip;
    } obj_job_t;

    typedef enum logic [1:0] {IDLE, CHECK, START, WAIT} scan_state_t;

endpackage

// ==== src/obj_scan.sv ====
/*
 * Sprite line scanner
 * Walks the table each line and issues a draw job per visible sprite
 */
`timescale 1ns/1ns
`include "obj_config.svh"

module obj_scan (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hstart,
    input  obj_pkg::line_t         vline,
    output logic [`OBJ_IDX_W-1:0]  rd_idx,
    input  obj_pkg::obj_entry_t    rd_entry,
    output logic                   start,
    output obj_pkg::obj_job_t      job,
    input  logic                   busy
);

    obj_pkg::scan_state_t  state;
    logic [`OBJ_IDX_W-1:0] idx;
    obj_pkg::line_t        line_q;   // Line being prepared
    obj_pkg::line_t        row;      // Row inside the sprite
    logic                  visible;
    logic                  last_idx;
    logic [15:0]           row_addr;

    assign rd_idx   = idx;
    assign row      = line_q - rd_entry.top;     // 8-bit wrap
    assign visible  = row < rd_entry.height;     // Zero height never matches
    assign last_idx = idx == `OBJ_IDX_W'(`OBJ_COUNT - 1);
    assign row_addr = rd_entry.offset + ({8'd0, row} * {8'd0, rd_entry.pitch});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= obj_pkg::IDLE;
            idx    <= '0;
            line_q <= '0;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;
            if (hstart) begin
                idx    <= '0;
                line_q <= vline + 8'd1;  // Render the next line
                state  <= obj_pkg::CHECK;
            end else begin
                case (state)
                    obj_pkg::CHECK: begin
                        if (visible) begin
                            start <= 1'b1;
                            state <= obj_pkg::START;
                        end else if (last_idx) begin
                            state <= obj_pkg::IDLE;
                        end else begin
                            idx <= idx + 1'b1; // One cycle per rejected entry
                        end
                    end
                    obj_pkg::START: state <= obj_pkg::WAIT; // Busy rises meanwhile
                    obj_pkg::WAIT: begin
                        if (!busy) begin
                            if (last_idx) begin
                                state <= obj_pkg::IDLE;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= obj_pkg::CHECK;
                            end
                        end
                    end
                    default: state <= obj_pkg::IDLE; // Hold until hstart
                endcase
            end
        end
    end

    // Job payload
    always_ff @(posedge clk) begin
        if (state == obj_pkg::CHECK && visible) begin
            job.xpos  <= rd_entry.xpos;
            job.addr  <= row_addr;
            job.bank  <= rd_entry.bank;
            job.prio  <= rd_entry.prio;
            job.pal   <= rd_entry.pal;
            job.hflip <= rd_entry.hflip;
        end
    end

    // Drawer must be idle whenever a job is issued
    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

// ==== src/obj_table.sv ====
/*
 * Sprite attribute table
 * Host writes whole entries, scanner reads combinationally
 */
`timescale 1ns/1ns
`include "obj_config.svh"

module obj_table (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tbl_we,
    input  logic [`OBJ_IDX_W-1:0]  tbl_addr,
    input  obj_pkg::obj_entry_t    tbl_wdata,
    input  logic [`OBJ_IDX_W-1:0]  rd_idx,
    output obj_pkg::obj_entry_t    rd_entry
);

    obj_pkg::obj_entry_t entry_mem [`OBJ_COUNT]; // Attribute storage
    logic [7:0]          height_q  [`OBJ_COUNT]; // Heights, cleared on reset

    // Entry fields
    always_ff @(posedge clk) begin
        if (tbl_we)
            entry_mem[tbl_addr] <= tbl_wdata;
    end

    // Height decides whether an entry is live
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `OBJ_COUNT; i++)
                height_q[i] <= 8'd0;       // All entries disabled
        end else if (tbl_we) begin
            height_q[tbl_addr] <= tbl_wdata.height;
        end
    end

    // Combinational read for single cycle test
    always_comb begin
        rd_entry        = entry_mem[rd_idx];
        rd_entry.height = height_q[rd_idx]; // Reset-safe height
    end

endmodule

// ==== src/obj_top.sv ====
/*
 * Sprite line renderer
 * Table, scanner, drawer and double line buffer
 */
`timescale 1ns/1ns
`include "obj_config.svh"

module obj_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   hstart,
    input  obj_pkg::line_t         vline,
    input  logic                   tbl_we,
    input  logic [`OBJ_IDX_W-1:0]  tbl_addr,
    input  obj_pkg::obj_entry_t    tbl_wdata,
    input  logic                   obj_ok,
    output logic                   obj_cs,
    output obj_pkg::rom_addr_t     obj_addr,
    input  obj_pkg::rom_word_t     obj_data,
    input  logic                   rd_en,
    input  obj_pkg::xpos_t         rd_addr,
    output obj_pkg::bf_pxl_t       rd_pxl
);

    logic [`OBJ_IDX_W-1:0] rd_idx;
    obj_pkg::obj_entry_t   rd_entry;
    obj_pkg::obj_job_t     job;
    logic                  start;
    logic                  busy;
    logic                  bf_we;
    obj_pkg::xpos_t        bf_addr;
    obj_pkg::bf_pxl_t      bf_data;

    obj_table obj_table_i (
        .clk, .rst, .tbl_we, .tbl_addr, .tbl_wdata, .rd_idx, .rd_entry
    );

    obj_scan obj_scan_i (
        .clk, .rst, .hstart, .vline, .rd_idx, .rd_entry, .start, .job, .busy
    );

    obj_draw obj_draw_i (
        .clk, .rst, .hstart, .start, .busy, .job, .obj_ok, .obj_cs, .obj_addr,
        .obj_data, .bf_we, .bf_addr, .bf_data
    );

    obj_linebuf obj_linebuf_i (
        .clk, .rst, .hstart, .bf_we, .bf_addr, .bf_data, .rd_en, .rd_addr, .rd_pxl
    );

endmodule

// ==== verif/obj_clkgen.sv ====
/*
 * Testbench clock and reset, 8 ns period, reset for 2 cycles
 */
`timescale 1ns/1ns

module obj_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 125 MHz
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;                    // Release on a rising edge
    end

endmodule

// ==== verif/obj_tb.sv ====
/*
 * Sprite renderer testbench
 * Random sprite tables, ROM model with variable latency,
 * reference line renderer, fetch address and read-and-clear checks
 */
`timescale 1ns/1ns
`include "obj_config.svh"

module obj_tb;

    localparam int          N_LINES = 8;
    localparam int          TIMEOUT = N_LINES * 3600 + 1000;  // Watchdog, in cycles
    localparam logic [31:0] SEED    = 32'hcdbefae2;

    logic                  clk;
    logic                  rst;
    logic                  hstart;
    obj_pkg::line_t        vline;
    logic                  tbl_we;
    logic [`OBJ_IDX_W-1:0] tbl_addr;
    obj_pkg::obj_entry_t   tbl_wdata;
    logic                  obj_ok   = 1'b0;   // Driven by the ROM model
    logic                  obj_cs;
    obj_pkg::rom_addr_t    obj_addr;
    obj_pkg::rom_word_t    obj_data = '0;
    logic                  rd_en;
    obj_pkg::xpos_t        rd_addr;
    obj_pkg::bf_pxl_t      rd_pxl;

    logic [31:0]           lfsr;
    int                    errors   = 0;
    obj_pkg::rom_word_t    rom [4096];        // Mirrored at every bank
    logic [2:0]            lat_tab [256];     // ROM latencies, 1 to 4
    logic [7:0]            lat_idx  = '0;
    logic [2:0]            rom_wait = '0;
    obj_pkg::obj_entry_t   entries [`OBJ_COUNT];
    obj_pkg::bf_pxl_t      model_line [512];
    obj_pkg::rom_addr_t    fetch_q [$];       // Expected word addresses in scan order
    logic                  check_fetch = 1'b0;

    obj_clkgen obj_clkgen_i (.clk, .rst);

    obj_top obj_top_i (
        .clk, .rst, .hstart, .vline, .tbl_we, .tbl_addr, .tbl_wdata, .obj_ok,
        .obj_cs, .obj_addr, .obj_data, .rd_en, .rd_addr, .rd_pxl
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return r;
    endfunction

    task automatic compare_value(input logic [31:0] got, input logic [31:0] want,
                                 input string what);
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, want);
        end
    endtask

    // Visible, disabled or just-missed entry around the given line
    function automatic obj_pkg::obj_entry_t make_entry(input obj_pkg::line_t line);
        obj_pkg::obj_entry_t e;
        logic [1:0]          mode;
        logic [7:0]          row;
        mode     = 2'(rand_bits(2));
        row      = 8'(rand_bits(5));
        e.top    = line - row;                        // May wrap below zero
        e.height = row + 8'd1 + 8'(rand_bits(4));
        if (mode == 2'd0)
            e.height = 8'd0;                          // Disabled
        else if (mode == 2'd1)
            e.height = row;                           // Ends one line short
        e.xpos   = 9'd440 + 9'(rand_bits(7));         // Crowded, wraps past 511
        e.offset = 16'(rand_bits(16));
        e.pitch  = 8'(rand_bits(8));
        e.bank   = 4'(rand_bits(4));
        e.prio   = 2'(rand_bits(2));
        e.pal    = 6'(rand_bits(6));
        e.hflip  = rand_bits(1) != 0;
        return e;
    endfunction

    // Reference drawing of one entry into the model line
    task automatic render_entry(input obj_pkg::obj_entry_t e, input obj_pkg::line_t line);
        obj_pkg::line_t     row;
        logic [15:0]        addr;
        obj_pkg::xpos_t     x;
        obj_pkg::rom_word_t w;
        logic [3:0]         p;
        logic               done;
        row = line - e.top;
        if (row >= e.height)
            return;                                   // Not on this line
        addr = e.offset + 16'(row) * 16'(e.pitch);
        x    = e.xpos;
        done = 1'b0;
        while (!done) begin
            fetch_q.push_back({e.bank, addr});        // Bank then offset
            w = rom[addr[11:0]];
            for (int k = 0; k < 4; k++) begin
                p = e.hflip ? w[4*k +: 4] : w[12-4*k +: 4];
                if (p != 4'hf)
                    model_line[x] = {e.prio, e.pal, p};
                x = x + 9'd1;                         // Advances even when transparent
            end
            done = p == 4'hf;                         // Last pixel ends the sprite
            addr = e.hflip ? addr - 16'd1 : addr + 16'd1;
        end
    endtask

    task automatic build_model(input obj_pkg::line_t line);
        fetch_q.delete();
        for (int a = 0; a < 512; a++)
            model_line[a] = '1;
        for (int i = 0; i < `OBJ_COUNT; i++)
            render_entry(entries[i], line);           // Later index overwrites
    endtask

    task automatic pulse_hstart(input obj_pkg::line_t v);
        @(posedge clk);
        hstart <= 1'b1;
        vline  <= v;
        @(posedge clk);
        hstart <= 1'b0;
    endtask

    // Pipelined reads, result checked one cycle after its address
    task automatic read_line(input int n, input logic again, input int count);
        obj_pkg::xpos_t   a;
        obj_pkg::xpos_t   prev;
        obj_pkg::bf_pxl_t want;
        prev = '0;
        for (int k = 0; k <= count; k++) begin
            a = again ? 9'd440 + 9'(4 * k) : 9'(k);
            @(posedge clk);
            rd_en   <= k < count;
            rd_addr <= a;
            @(negedge clk);
            if (k > 0) begin
                want = again ? '1 : model_line[prev];  // Second read sees cleared
                compare_value(rd_pxl, want, $sformatf("line %0d pixel %0d%s", n, prev,
                              again ? " reread" : ""));
            end
            prev = a;
        end
    endtask

    task automatic run_line(input int n);
        obj_pkg::line_t      vl;
        obj_pkg::obj_entry_t e;
        vl = 8'(rand_bits(8));
        for (int i = 0; i < `OBJ_COUNT; i++) begin
            e          = make_entry(vl + 8'd1);
            entries[i] = e;
            @(posedge clk);
            tbl_we    <= 1'b1;
            tbl_addr  <= `OBJ_IDX_W'(i);
            tbl_wdata <= e;
        end
        @(posedge clk);
        tbl_we <= 1'b0;
        build_model(vl + 8'd1);
        pulse_hstart(vl);                             // Draw the line after vl
        check_fetch <= 1'b1;                          // Fetches of this line only
        repeat (3000) @(posedge clk);
        check_fetch <= 1'b0;
        compare_value(fetch_q.size(), 0, $sformatf("line %0d ROM fetches missing", n));
        pulse_hstart(vl + 8'd1);                      // Swap, drawn half to video
        read_line(n, 1'b0, 512);
        read_line(n, 1'b1, 16);
    endtask

    // ROM model, request dropped whenever obj_cs falls
    always @(posedge clk) begin
        obj_ok <= 1'b0;
        if (!obj_cs) begin
            rom_wait <= 3'd0;
        end else if (rom_wait == 3'd1) begin
            obj_ok   <= 1'b1;
            obj_data <= rom[obj_addr[11:0]];
            rom_wait <= 3'd0;
        end else if (rom_wait != 3'd0) begin
            rom_wait <= rom_wait - 3'd1;
        end else if (!obj_ok) begin
            rom_wait <= lat_tab[lat_idx];             // New fetch
            lat_idx  <= lat_idx + 8'd1;
            if (check_fetch) begin
                if (fetch_q.size() == 0) begin
                    errors++;
                    $display("ROM fetch at address %h after the last expected word",
                             obj_addr);
                end else begin
                    compare_value(obj_addr, fetch_q.pop_front(), "ROM fetch address");
                end
            end
        end
    end

    initial begin
        obj_pkg::rom_word_t w;
        lfsr = SEED;
        for (int i = 0; i < 4096; i++) begin
            w = 16'(rand_bits(16));
            if (i % 8 == 7)
                w[3:0] = 4'hf;                        // End marker, rising addresses
            if (i % 8 == 0)
                w[15:12] = 4'hf;                      // End marker, falling addresses
            rom[i] = w;
        end
        for (int i = 0; i < 256; i++)
            lat_tab[i] = 3'd1 + 3'(rand_bits(2));
        hstart    = 1'b0;
        vline     = '0;
        tbl_we    = 1'b0;
        tbl_addr  = '0;
        tbl_wdata = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        @(negedge rst);
        repeat (520) @(posedge clk);                  // Line buffer fill
        for (int n = 0; n < N_LINES; n++)
            run_line(n);
        $display("Run complete, %0d errors", errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", TIMEOUT);
        $display("Errors before timeout: %0d", errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/obj_pkg.sv
src/obj_table.sv
src/obj_scan.sv
src/obj_draw.sv
src/obj_linebuf.sv
src/obj_top.sv
verif/obj_clkgen.sv
verif/obj_tb.sv
